//--- hdl/pit_pkg.sv
package pit_pkg;

	// ==============================
	// sizes
	// ==============================

	// number of timers and counter width
	localparam int NTIMER = 4;
	localparam int CNT_W  = 32;

	// bus word address and data widths
	localparam int ADDR_W = 7;
	localparam int DATA_W = 32;

	// low address bits pick the register inside a timer group
	localparam int OFS_W  = 2;
	// timer select bits right above the offset
	localparam int TSEL_W = $clog2(NTIMER);
	// upper bits name the group of four words
	localparam int GRP_W  = ADDR_W - OFS_W;

	// ==============================
	// register map
	// ==============================

	// per-timer offsets, timer n sits at words n*4 .. n*4+3
	localparam logic [OFS_W-1:0] REG_COUNT = 2'd0;
	localparam logic [OFS_W-1:0] REG_MAX   = 2'd1;
	localparam logic [OFS_W-1:0] REG_ON    = 2'd2;
	localparam logic [OFS_W-1:0] REG_CTRL  = 2'd3;

	// global registers above the timer groups
	localparam logic [ADDR_W-1:0] REG_UFLOW     = 7'h40;
	localparam logic [ADDR_W-1:0] REG_SYNC      = 7'h41;
	localparam logic [ADDR_W-1:0] REG_IE        = 7'h42;
	localparam logic [ADDR_W-1:0] REG_OUT       = 7'h43;
	localparam logic [ADDR_W-1:0] REG_IGATE     = 7'h44;
	localparam logic [ADDR_W-1:0] REG_IGATE_SET = 7'h45;
	localparam logic [ADDR_W-1:0] REG_IGATE_CLR = 7'h46;

	// control word bit positions
	localparam int CTRL_LD  = 0;
	localparam int CTRL_CE  = 1;
	localparam int CTRL_AR  = 2;
	localparam int CTRL_XC  = 3;
	localparam int CTRL_GE  = 4;
	localparam int CTRL_NOW = 7;

endpackage

//--- hdl/pit_timer_if.sv
`timescale 1ns/10ps

interface pit_timer_if;
	import pit_pkg::*;

	// holding side, written over the bus
	logic             apply;
	logic [CNT_W-1:0] hold_max;
	logic [CNT_W-1:0] hold_on;
	logic             hold_ld;
	logic             hold_ce;
	logic             hold_ar;
	logic             hold_xc;
	logic             hold_ge;
	// internal gate bit for this timer
	logic             igate_en;

	// active side, kept by the channel
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] max_q;
	logic [CNT_W-1:0] on_q;
	logic             ce_q;
	logic             ar_q;
	logic             xc_q;
	logic             ge_q;
	logic             out_q;
	// single cycle at terminal count
	logic             uflow;

	modport regs (
		output apply, hold_max, hold_on, hold_ld, hold_ce, hold_ar, hold_xc, hold_ge, igate_en,
		input  count, max_q, on_q, ce_q, ar_q, xc_q, ge_q, out_q, uflow
	);

	modport chan (
		input  apply, hold_max, hold_on, hold_ld, hold_ce, hold_ar, hold_xc, hold_ge, igate_en,
		output count, max_q, on_q, ce_q, ar_q, xc_q, ge_q, out_q, uflow
	);

endinterface

//--- hdl/pit_ext_sync.sv
`timescale 1ns/10ps

module pit_ext_sync (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [pit_pkg::NTIMER-1:0] ext_clk_i,
	input  logic [pit_pkg::NTIMER-1:0] gate_i,
	output logic [pit_pkg::NTIMER-1:0] ext_pulse_o,
	output logic [pit_pkg::NTIMER-1:0] gate_o
);
	import pit_pkg::*;

	// external clock path, two sync stages then edge detect
	logic [NTIMER-1:0] clk_meta;
	logic [NTIMER-1:0] clk_sync;
	logic [NTIMER-1:0] clk_last;
	logic [NTIMER-1:0] pulse_q;
	// gate path, two sync stages only
	logic [NTIMER-1:0] gate_meta;
	logic [NTIMER-1:0] gate_sync;

	always_ff @(posedge clk) begin
		if (rst) begin
			clk_meta  <= '0;
			clk_sync  <= '0;
			clk_last  <= '0;
			pulse_q   <= '0;
			gate_meta <= '0;
			gate_sync <= '0;
		end else begin
			clk_meta  <= ext_clk_i;
			clk_sync  <= clk_meta;
			clk_last  <= clk_sync;
			// rising edge seen after sync, one cycle wide
			pulse_q   <= clk_sync & ~clk_last;
			gate_meta <= gate_i;
			gate_sync <= gate_meta;
		end
	end

	assign ext_pulse_o = pulse_q;
	assign gate_o      = gate_sync;

endmodule

//--- hdl/pit_channel.sv
`timescale 1ns/10ps

module pit_channel (
	input  logic          clk,
	input  logic          rst,
	pit_timer_if.chan     tmr,
	input  logic          ext_pulse_i,
	input  logic          gate_i
);

	// load request, lives one cycle after an apply
	logic ld_q;
	// count step qualifier
	logic step;

	// ce gates everything
	// xc waits for an external edge
	// ge needs both the pin gate and the internal gate
	assign step = tmr.ce_q
		& (~tmr.xc_q | ext_pulse_i)
		& (~tmr.ge_q | (gate_i & tmr.igate_en));

	// ==============================
	// counter and output
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			tmr.count <= '0;
			tmr.max_q <= '0;
			tmr.on_q  <= '0;
			ld_q      <= 1'b0;
			tmr.ce_q  <= 1'b0;
			tmr.ar_q  <= 1'b1;
			tmr.xc_q  <= 1'b0;
			tmr.ge_q  <= 1'b0;
			tmr.out_q <= 1'b0;
			tmr.uflow <= 1'b0;
		end else begin
			tmr.uflow <= 1'b0;
			ld_q      <= 1'b0;
			if (ld_q) begin
				// load has priority over counting
				tmr.count <= tmr.max_q;
			end else if (step) begin
				tmr.count <= tmr.count - 1'b1;
				if (tmr.count == tmr.on_q) begin
					tmr.out_q <= 1'b1;
				end else if (tmr.count == '0) begin
					tmr.out_q <= 1'b0;
					tmr.uflow <= 1'b1;
					// periodic mode reloads, one-shot stops and wraps to all ones
					if (tmr.ar_q)
						tmr.count <= tmr.max_q;
					else
						tmr.ce_q <= 1'b0;
				end
			end
			// held settings become active, load follows next cycle
			if (tmr.apply) begin
				tmr.max_q <= tmr.hold_max;
				tmr.on_q  <= tmr.hold_on;
				ld_q      <= tmr.hold_ld;
				tmr.ce_q  <= tmr.hold_ce;
				tmr.ar_q  <= tmr.hold_ar;
				tmr.xc_q  <= tmr.hold_xc;
				tmr.ge_q  <= tmr.hold_ge;
			end
		end
	end

	// ==============================
	// checks
	// ==============================

	// terminal count only comes from a step taken while enabled
	a_uflow_needs_ce: assert property (@(posedge clk) disable iff (rst)
		tmr.uflow |-> $past(tmr.ce_q));

	// register block keeps apply quiet across reset
	a_no_apply_in_rst: assert property (@(posedge clk)
		rst |=> !tmr.apply);

endmodule

//--- hdl/pit_regfile.sv
`timescale 1ns/10ps

module pit_regfile (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       req_i,
	input  logic                       we_i,
	input  logic [pit_pkg::ADDR_W-1:0] addr_i,
	input  logic [pit_pkg::DATA_W-1:0] wdata_i,
	output logic [pit_pkg::DATA_W-1:0] rdata_o,
	output logic                       ack_o,
	output logic                       irq_o,
	pit_timer_if.regs                  tmr [pit_pkg::NTIMER]
);
	import pit_pkg::*;

	logic              wr_en;
	logic              wr_sync;
	// global state
	logic [NTIMER-1:0] ie;
	logic [NTIMER-1:0] igate;
	logic [NTIMER-1:0] uflow_st;
	logic [NTIMER-1:0] irq_f;
	// bus response
	logic              ack_q;
	logic [DATA_W-1:0] rdata_q;
	logic [DATA_W-1:0] rd_mux;
	logic [TSEL_W-1:0] tsel;
	// channel status gathered into plain arrays for indexing
	logic [CNT_W-1:0]  cnt_a [NTIMER];
	logic [CNT_W-1:0]  max_a [NTIMER];
	logic [CNT_W-1:0]  on_a  [NTIMER];
	logic [NTIMER-1:0] ce_v;
	logic [NTIMER-1:0] ar_v;
	logic [NTIMER-1:0] xc_v;
	logic [NTIMER-1:0] ge_v;
	logic [NTIMER-1:0] out_v;
	logic [NTIMER-1:0] uflow_v;

	assign wr_en   = req_i & we_i;
	assign wr_sync = wr_en & (addr_i == REG_SYNC);
	assign tsel    = addr_i[OFS_W +: TSEL_W];

	// ==============================
	// per-timer holding registers
	// ==============================

	for (genvar g = 0; g < NTIMER; g++) begin : g_tmr
		logic             hit;
		logic [CNT_W-1:0] max_h;
		logic [CNT_W-1:0] on_h;
		logic             ld_h;
		logic             ce_h;
		logic             ar_h;
		logic             xc_h;
		logic             ge_h;
		logic             apply_q;
		// apply came from the sync register
		logic             sync_q;

		assign hit = wr_en & (addr_i[ADDR_W-1:OFS_W] == GRP_W'(g));

		always_ff @(posedge clk) begin
			if (rst) begin
				max_h   <= '0;
				on_h    <= '0;
				ld_h    <= 1'b0;
				ce_h    <= 1'b0;
				ar_h    <= 1'b1;
				xc_h    <= 1'b0;
				ge_h    <= 1'b0;
				apply_q <= 1'b0;
				sync_q  <= 1'b0;
			end else begin
				apply_q <= (hit & (addr_i[OFS_W-1:0] == REG_CTRL) & wdata_i[CTRL_NOW])
					| (wr_sync & wdata_i[g]);
				sync_q  <= wr_sync & wdata_i[g];
				// held load is one use only after a sync apply
				if (sync_q)
					ld_h <= 1'b0;
				if (hit) begin
					case (addr_i[OFS_W-1:0])
						REG_MAX: max_h <= wdata_i[CNT_W-1:0];
						REG_ON:  on_h  <= wdata_i[CNT_W-1:0];
						REG_CTRL: begin
							ld_h <= wdata_i[CTRL_LD];
							ce_h <= wdata_i[CTRL_CE];
							ar_h <= wdata_i[CTRL_AR];
							xc_h <= wdata_i[CTRL_XC];
							ge_h <= wdata_i[CTRL_GE];
						end
						default: ;
					endcase
				end
			end
		end

		assign tmr[g].apply    = apply_q;
		assign tmr[g].hold_max = max_h;
		assign tmr[g].hold_on  = on_h;
		assign tmr[g].hold_ld  = ld_h;
		assign tmr[g].hold_ce  = ce_h;
		assign tmr[g].hold_ar  = ar_h;
		assign tmr[g].hold_xc  = xc_h;
		assign tmr[g].hold_ge  = ge_h;
		assign tmr[g].igate_en = igate[g];

		assign cnt_a[g]   = tmr[g].count;
		assign max_a[g]   = tmr[g].max_q;
		assign on_a[g]    = tmr[g].on_q;
		assign ce_v[g]    = tmr[g].ce_q;
		assign ar_v[g]    = tmr[g].ar_q;
		assign xc_v[g]    = tmr[g].xc_q;
		assign ge_v[g]    = tmr[g].ge_q;
		assign out_v[g]   = tmr[g].out_q;
		assign uflow_v[g] = tmr[g].uflow;
	end

	// ==============================
	// read mux
	// ==============================

	always_comb begin
		rd_mux = '0;
		if (addr_i[ADDR_W-1:OFS_W+TSEL_W] == '0) begin
			case (addr_i[OFS_W-1:0])
				REG_COUNT: rd_mux[CNT_W-1:0] = cnt_a[tsel];
				REG_MAX:   rd_mux[CNT_W-1:0] = max_a[tsel];
				REG_ON:    rd_mux[CNT_W-1:0] = on_a[tsel];
				REG_CTRL: begin
					// ld always reads back zero
					rd_mux[CTRL_CE] = ce_v[tsel];
					rd_mux[CTRL_AR] = ar_v[tsel];
					rd_mux[CTRL_XC] = xc_v[tsel];
					rd_mux[CTRL_GE] = ge_v[tsel];
				end
				default: ;
			endcase
		end else begin
			case (addr_i)
				REG_UFLOW: rd_mux[NTIMER-1:0] = uflow_st;
				REG_IE:    rd_mux[NTIMER-1:0] = ie;
				REG_OUT:   rd_mux[NTIMER-1:0] = out_v;
				REG_IGATE: rd_mux[NTIMER-1:0] = igate;
				// write-only masks and holes read zero
				default: ;
			endcase
		end
	end

	// ==============================
	// global registers and response
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			ie       <= '0;
			igate    <= '0;
			uflow_st <= '0;
			irq_f    <= '0;
			ack_q    <= 1'b0;
			rdata_q  <= '0;
		end else begin
			ack_q   <= req_i;
			rdata_q <= (req_i & ~we_i) ? rd_mux : '0;
			if (wr_en) begin
				case (addr_i)
					REG_UFLOW: begin
						// acknowledge also drops the enable
						uflow_st <= uflow_st & ~wdata_i[NTIMER-1:0];
						irq_f    <= irq_f & ~wdata_i[NTIMER-1:0];
						ie       <= ie & ~wdata_i[NTIMER-1:0];
					end
					REG_IE:        ie    <= wdata_i[NTIMER-1:0];
					REG_IGATE:     igate <= wdata_i[NTIMER-1:0];
					REG_IGATE_SET: igate <= igate | wdata_i[NTIMER-1:0];
					REG_IGATE_CLR: igate <= igate & ~wdata_i[NTIMER-1:0];
					default: ;
				endcase
			end
			// a fresh underflow wins over a clear in the same cycle
			for (int i = 0; i < NTIMER; i++) begin
				if (uflow_v[i]) begin
					uflow_st[i] <= 1'b1;
					if (ie[i])
						irq_f[i] <= 1'b1;
				end
			end
		end
	end

	assign ack_o   = ack_q;
	assign rdata_o = rdata_q;
	assign irq_o   = |irq_f;

	// every ack answers the request of the previous cycle
	a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
		ack_o |-> $past(req_i));

endmodule

//--- hdl/pit_top.sv
`timescale 1ns/10ps

module pit_top (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       req_i,
	input  logic                       we_i,
	input  logic [pit_pkg::ADDR_W-1:0] addr_i,
	input  logic [pit_pkg::DATA_W-1:0] wdata_i,
	input  logic [pit_pkg::NTIMER-1:0] ext_clk_i,
	input  logic [pit_pkg::NTIMER-1:0] gate_i,
	output logic [pit_pkg::DATA_W-1:0] rdata_o,
	output logic                       ack_o,
	output logic                       irq_o,
	output logic [pit_pkg::NTIMER-1:0] out_o
);
	import pit_pkg::*;

	// synchronized external inputs
	logic [NTIMER-1:0] ext_pulse;
	logic [NTIMER-1:0] gate_q;

	// one link per timer between register block and channel
	pit_timer_if tmr_if [NTIMER] ();

	pit_ext_sync u_sync (
		.clk         (clk),
		.rst         (rst),
		.ext_clk_i   (ext_clk_i),
		.gate_i      (gate_i),
		.ext_pulse_o (ext_pulse),
		.gate_o      (gate_q)
	);

	pit_regfile u_regs (
		.clk     (clk),
		.rst     (rst),
		.req_i   (req_i),
		.we_i    (we_i),
		.addr_i  (addr_i),
		.wdata_i (wdata_i),
		.rdata_o (rdata_o),
		.ack_o   (ack_o),
		.irq_o   (irq_o),
		.tmr     (tmr_if)
	);

	// ==============================
	// timer channels
	// ==============================

	for (genvar g = 0; g < NTIMER; g++) begin : g_chan
		pit_channel u_chan (
			.clk         (clk),
			.rst         (rst),
			.tmr         (tmr_if[g]),
			.ext_pulse_i (ext_pulse[g]),
			.gate_i      (gate_q[g])
		);
		assign out_o[g] = tmr_if[g].out_q;
	end

endmodule

//--- dv/pit_checker.sv
`timescale 1ns/10ps

module pit_checker (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       ack_i,
	input  logic [pit_pkg::DATA_W-1:0] rdata_i,
	input  logic [pit_pkg::NTIMER-1:0] out_i,
	input  logic                       irq_i,
	input  logic                       exp_ack_i,
	input  logic [pit_pkg::DATA_W-1:0] exp_rdata_i,
	input  logic [pit_pkg::NTIMER-1:0] exp_out_i,
	input  logic                       exp_irq_i,
	input  logic [8*12-1:0]            test_name_i,
	output int                         errors_o
);
	import pit_pkg::*;

	// running mismatch count
	int errors;

	initial errors = 0;

	assign errors_o = errors;

	// one compare that prints one line on a difference
	task automatic compare_value(input string what, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		if (exp_v !== act_v) begin
			$display("MISMATCH %0s %0s: expected %h actual %h", test_name_i, what, exp_v, act_v);
			errors++;
		end
	endtask

	// ==============================
	// per-cycle watch
	// ==============================

	// DUT and model have both settled by the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			// ack follows each request by one cycle
			compare_value("ack", 32'(exp_ack_i), 32'(ack_i));
			// read data stays zero outside a read ack
			compare_value("rdata", exp_rdata_i, rdata_i);
			compare_value("out", 32'(exp_out_i), 32'(out_i));
			compare_value("irq", 32'(exp_irq_i), 32'(irq_i));
		end
	end

endmodule

//--- dv/pit_tb.sv
`timescale 1ns/10ps

module pit_tb;
	import pit_pkg::*;

	logic              clk;
	logic              rst;
	logic              req;
	logic              we;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic [NTIMER-1:0] ext_clk;
	logic [NTIMER-1:0] gate;
	logic [DATA_W-1:0] rdata;
	logic              ack;
	logic              irq;
	logic [NTIMER-1:0] out;
	// model outputs toward the checker
	logic              exp_ack;
	logic [DATA_W-1:0] exp_rdata;
	logic [NTIMER-1:0] exp_out;
	logic              exp_irq;
	logic [8*12-1:0]   test_name;
	int                chk_errors;
	int                timeouts;
	int                err_mark;
	int                n_tests;
	int                n_failed;

	// model state of the channel side
	logic [CNT_W-1:0]  m_count [NTIMER];
	logic [CNT_W-1:0]  m_max   [NTIMER];
	logic [CNT_W-1:0]  m_on    [NTIMER];
	logic [NTIMER-1:0] m_ce;
	logic [NTIMER-1:0] m_ar;
	logic [NTIMER-1:0] m_xc;
	logic [NTIMER-1:0] m_ge;
	logic [NTIMER-1:0] m_out;
	logic [NTIMER-1:0] m_uf;
	logic [NTIMER-1:0] m_ld;
	// model state of the register side
	logic [CNT_W-1:0]  h_max [NTIMER];
	logic [CNT_W-1:0]  h_on  [NTIMER];
	logic [NTIMER-1:0] h_ld;
	logic [NTIMER-1:0] h_ce;
	logic [NTIMER-1:0] h_ar;
	logic [NTIMER-1:0] h_xc;
	logic [NTIMER-1:0] h_ge;
	logic [NTIMER-1:0] m_apply;
	logic [NTIMER-1:0] m_syncq;
	logic [NTIMER-1:0] m_ie;
	logic [NTIMER-1:0] m_igate;
	logic [NTIMER-1:0] m_ust;
	logic [NTIMER-1:0] m_irqf;
	// model of the external sync stages
	logic [NTIMER-1:0] s_meta;
	logic [NTIMER-1:0] s_sync;
	logic [NTIMER-1:0] s_last;
	logic [NTIMER-1:0] s_pulse;
	logic [NTIMER-1:0] s_gmeta;
	logic [NTIMER-1:0] s_gsync;

	pit_top u_dut (
		.clk (clk), .rst (rst), .req_i (req), .we_i (we), .addr_i (addr),
		.wdata_i (wdata), .ext_clk_i (ext_clk), .gate_i (gate),
		.rdata_o (rdata), .ack_o (ack), .irq_o (irq), .out_o (out)
	);

	pit_checker u_chk (
		.clk (clk), .rst (rst), .ack_i (ack), .rdata_i (rdata), .out_i (out),
		.irq_i (irq), .exp_ack_i (exp_ack), .exp_rdata_i (exp_rdata),
		.exp_out_i (exp_out), .exp_irq_i (exp_irq), .test_name_i (test_name),
		.errors_o (chk_errors)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ==============================
	// reference model
	// ==============================

	// what a read of address a returns right now
	function automatic logic [31:0] model_read(input logic [ADDR_W-1:0] a);
		logic [31:0] r;
		int t;
		r = '0;
		t = a[OFS_W +: TSEL_W];
		if (a[ADDR_W-1:OFS_W+TSEL_W] == '0) begin
			case (a[OFS_W-1:0])
				REG_COUNT: r = m_count[t];
				REG_MAX:   r = m_max[t];
				REG_ON:    r = m_on[t];
				default: begin
					r[CTRL_CE] = m_ce[t];
					r[CTRL_AR] = m_ar[t];
					r[CTRL_XC] = m_xc[t];
					r[CTRL_GE] = m_ge[t];
				end
			endcase
		end else begin
			case (a)
				REG_UFLOW: r[NTIMER-1:0] = m_ust;
				REG_IE:    r[NTIMER-1:0] = m_ie;
				REG_OUT:   r[NTIMER-1:0] = m_out;
				REG_IGATE: r[NTIMER-1:0] = m_igate;
				default: ;
			endcase
		end
		return r;
	endfunction

	always @(posedge clk) begin : model
		logic [NTIMER-1:0] uf_old;
		logic [NTIMER-1:0] ie_old;
		logic              ld_old;
		logic              step;
		logic              hit;
		logic              wr_sync;
		logic [CNT_W-1:0]  c_old;
		if (rst) begin
			for (int g = 0; g < NTIMER; g++) begin
				m_count[g] = '0;
				m_max[g] = '0;
				m_on[g] = '0;
				h_max[g] = '0;
				h_on[g] = '0;
			end
			{m_ce, m_xc, m_ge, m_out, m_uf, m_ld} = '0;
			{h_ld, h_ce, h_xc, h_ge, m_apply, m_syncq} = '0;
			{m_ie, m_igate, m_ust, m_irqf} = '0;
			{s_meta, s_sync, s_last, s_pulse, s_gmeta, s_gsync} = '0;
			m_ar = '1;
			h_ar = '1;
			exp_ack = 1'b0;
			exp_rdata = '0;
		end else begin
			// every request is answered one cycle later
			exp_ack = req;
			// read sees the state before this edge
			exp_rdata = (req && !we) ? model_read(addr) : '0;
			uf_old = m_uf;
			ie_old = m_ie;
			wr_sync = req && we && addr == REG_SYNC;
			// channels count first and then apply
			for (int g = 0; g < NTIMER; g++) begin
				m_uf[g] = 1'b0;
				ld_old = m_ld[g];
				m_ld[g] = 1'b0;
				step = m_ce[g] && (!m_xc[g] || s_pulse[g])
					&& (!m_ge[g] || (s_gsync[g] && m_igate[g]));
				if (ld_old) begin
					m_count[g] = m_max[g];
				end else if (step) begin
					c_old = m_count[g];
					m_count[g] = c_old - 1;
					if (c_old == m_on[g]) begin
						m_out[g] = 1'b1;
					end else if (c_old == '0) begin
						m_out[g] = 1'b0;
						m_uf[g] = 1'b1;
						if (m_ar[g])
							m_count[g] = m_max[g];
						else
							m_ce[g] = 1'b0;
					end
				end
				if (m_apply[g]) begin
					m_max[g] = h_max[g];
					m_on[g] = h_on[g];
					m_ld[g] = h_ld[g];
					m_ce[g] = h_ce[g];
					m_ar[g] = h_ar[g];
					m_xc[g] = h_xc[g];
					m_ge[g] = h_ge[g];
				end
			end
			// holding registers and apply pulses
			for (int g = 0; g < NTIMER; g++) begin
				hit = req && we && addr[ADDR_W-1:OFS_W] == g;
				m_apply[g] = (hit && addr[OFS_W-1:0] == REG_CTRL && wdata[CTRL_NOW])
					|| (wr_sync && wdata[g]);
				if (m_syncq[g])
					h_ld[g] = 1'b0;
				m_syncq[g] = wr_sync && wdata[g];
				if (hit && addr[OFS_W-1:0] == REG_MAX)
					h_max[g] = wdata;
				if (hit && addr[OFS_W-1:0] == REG_ON)
					h_on[g] = wdata;
				if (hit && addr[OFS_W-1:0] == REG_CTRL) begin
					h_ld[g] = wdata[CTRL_LD];
					h_ce[g] = wdata[CTRL_CE];
					h_ar[g] = wdata[CTRL_AR];
					h_xc[g] = wdata[CTRL_XC];
					h_ge[g] = wdata[CTRL_GE];
				end
			end
			// global registers
			if (req && we) begin
				case (addr)
					REG_UFLOW: begin
						m_ust  = m_ust & ~wdata[NTIMER-1:0];
						m_irqf = m_irqf & ~wdata[NTIMER-1:0];
						m_ie   = m_ie & ~wdata[NTIMER-1:0];
					end
					REG_IE:        m_ie = wdata[NTIMER-1:0];
					REG_IGATE:     m_igate = wdata[NTIMER-1:0];
					REG_IGATE_SET: m_igate = m_igate | wdata[NTIMER-1:0];
					REG_IGATE_CLR: m_igate = m_igate & ~wdata[NTIMER-1:0];
					default: ;
				endcase
			end
			// a new underflow beats a clear
			m_ust  = m_ust | uf_old;
			m_irqf = m_irqf | (uf_old & ie_old);
			// external pins pass two stages and then the edge detect
			s_pulse = s_sync & ~s_last;
			s_last  = s_sync;
			s_sync  = s_meta;
			s_meta  = ext_clk;
			s_gsync = s_gmeta;
			s_gmeta = gate;
		end
		exp_out = m_out;
		exp_irq = |m_irqf;
	end

	// ==============================
	// bus and wait helpers
	// ==============================

	task automatic report_timeout(input string what);
		$display("timeout in %0s: %0s did not happen in time", test_name, what);
		timeouts++;
	endtask

	// ack is due one cycle after the request
	task automatic wait_ack(output logic [DATA_W-1:0] d);
		int n;
		n = 0;
		while (!ack && n < 8) begin
			@(negedge clk);
			n++;
		end
		if (!ack)
			report_timeout("bus ack");
		d = rdata;
	endtask

	task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
		logic [DATA_W-1:0] dummy;
		@(negedge clk);
		req = 1'b1;
		we = 1'b1;
		addr = a;
		wdata = d;
		@(negedge clk);
		req = 1'b0;
		we = 1'b0;
		wait_ack(dummy);
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d);
		@(negedge clk);
		req = 1'b1;
		we = 1'b0;
		addr = a;
		@(negedge clk);
		req = 1'b0;
		wait_ack(d);
	endtask

	task automatic wait_out(input int idx, input logic level, input int limit);
		int n;
		n = 0;
		while (out[idx] !== level && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (out[idx] !== level)
			report_timeout("out level change");
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic start_test(input logic [8*12-1:0] name);
		test_name = name;
		err_mark = chk_errors + timeouts;
		n_tests++;
	endtask

	task automatic end_test();
		if (chk_errors + timeouts == err_mark) begin
			$display("test %0s passed", test_name);
		end else begin
			$display("test %0s FAILED", test_name);
			n_failed++;
		end
	endtask

	// ==============================
	// tests
	// ==============================

	task automatic run_readback();
		logic [DATA_W-1:0] d;
		start_test("readback");
		for (int t = 0; t < NTIMER; t++) begin
			bus_write(ADDR_W'(t * 4 + 1), $urandom);
			bus_write(ADDR_W'(t * 4 + 2), $urandom);
			// ce stays off here while the rest is random
			bus_write(ADDR_W'(t * 4 + 3), 32'h80 | ($urandom & 32'h1d));
			for (int r = 0; r < 4; r++)
				bus_read(ADDR_W'(t * 4 + r), d);
		end
		bus_write(REG_IE, $urandom);
		bus_read(REG_IE, d);
		bus_write(REG_IGATE, $urandom);
		bus_read(REG_IGATE, d);
		bus_write(REG_IGATE_SET, $urandom);
		bus_read(REG_IGATE, d);
		bus_write(REG_IGATE_CLR, $urandom);
		bus_read(REG_IGATE, d);
		bus_write(REG_IE, 32'h0);
		end_test();
	endtask

	task automatic run_one_shot();
		logic [DATA_W-1:0] d;
		int mx;
		start_test("one_shot");
		mx = 4 + $urandom % 12;
		bus_write(REG_MAX, mx);
		bus_write(REG_ON, 1 + $urandom % (mx - 1));
		bus_write(REG_CTRL, 32'h83);
		wait_out(0, 1'b1, 100);
		wait_out(0, 1'b0, 100);
		idle(4);
		bus_read(REG_UFLOW, d);
		bus_read(REG_CTRL, d);
		bus_read(REG_COUNT, d);
		u_chk.compare_value("one-shot count", 32'hffff_ffff, d);
		end_test();
	endtask

	task automatic run_reload_irq();
		logic [DATA_W-1:0] d;
		int n;
		start_test("reload_irq");
		bus_write(REG_IE, 32'h2);
		bus_write(5, 3 + $urandom % 6);
		bus_write(6, 1);
		bus_write(7, 32'h87);
		// two terminal counts that each raise irq
		for (int k = 0; k < 2; k++) begin
			n = 0;
			while (!irq && n < 100) begin
				@(negedge clk);
				n++;
			end
			if (!irq)
				report_timeout("irq");
			bus_write(REG_UFLOW, 32'h2);
			bus_read(REG_IE, d);
			bus_read(REG_UFLOW, d);
			bus_write(REG_IE, 32'h2);
		end
		bus_write(REG_IE, 32'h0);
		// stop the periodic timer again
		bus_write(7, 32'h84);
		end_test();
	endtask

	task automatic run_sync_start();
		logic [DATA_W-1:0] d;
		logic [NTIMER-1:0] mask;
		start_test("sync_start");
		mask = 4'(1 + $urandom % 15);
		for (int t = 0; t < NTIMER; t++) begin
			if (mask[t]) begin
				bus_write(ADDR_W'(t * 4 + 1), 1000 + $urandom % 1000);
				bus_write(ADDR_W'(t * 4 + 2), 0);
				bus_write(ADDR_W'(t * 4 + 3), 32'h07);
			end
		end
		for (int t = 0; t < NTIMER; t++)
			bus_read(ADDR_W'(t * 4), d);
		bus_write(REG_SYNC, mask);
		idle(3);
		for (int t = 0; t < NTIMER; t++)
			bus_read(ADDR_W'(t * 4), d);
		// stop them but keep the rest of the settings
		for (int t = 0; t < NTIMER; t++)
			bus_write(ADDR_W'(t * 4 + 3), 32'h84);
		end_test();
	endtask

	task automatic run_ext_gate();
		logic [DATA_W-1:0] d;
		logic              g_pin;
		logic              g_int;
		int                edges;
		int                counted;
		start_test("ext_gate");
		counted = 0;
		edges = 4 + $urandom % 8;
		bus_write(13, 1000);
		bus_write(14, 2000);
		bus_write(15, 32'h9f);
		for (int k = 0; k < edges; k++) begin
			g_pin = ($urandom % 4) != 0;
			g_int = ($urandom % 4) != 0;
			gate[3] = g_pin;
			bus_write(g_int ? REG_IGATE_SET : REG_IGATE_CLR, 32'h8);
			// gates settle before the edge arrives
			idle(4);
			ext_clk[3] = 1'b1;
			idle(4);
			ext_clk[3] = 1'b0;
			idle(4);
			if (g_pin && g_int)
				counted++;
		end
		idle(8);
		bus_read(12, d);
		u_chk.compare_value("ext count", 32'(1000 - counted), d);
		end_test();
	endtask

	initial begin
		int seed;
		seed = $urandom(32'h4e61_42b7);
		rst = 1'b1;
		req = 1'b0;
		we = 1'b0;
		addr = '0;
		wdata = '0;
		ext_clk = '0;
		gate = '0;
		test_name = "reset";
		timeouts = 0;
		n_tests = 0;
		n_failed = 0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		run_readback();
		run_one_shot();
		run_reload_irq();
		run_sync_start();
		run_ext_gate();
		idle(4);
		$display("tests %0d, failed %0d, mismatches %0d, timeouts %0d",
			n_tests, n_failed, chk_errors, timeouts);
		if (n_failed != 0 || chk_errors != 0 || timeouts != 0) begin
			$display("Simulation failed");
		end else begin
			$display("Simulation completed successfully");
		end
		$finish;
	end

endmodule

//--- filelist.f
hdl/pit_pkg.sv
hdl/pit_timer_if.sv
hdl/pit_ext_sync.sv
hdl/pit_channel.sv
hdl/pit_regfile.sv
hdl/pit_top.sv
dv/pit_checker.sv
dv/pit_tb.sv

//--- Bender.yml
package:
  name: pit

sources:
  - hdl/pit_pkg.sv
  - hdl/pit_timer_if.sv
  - hdl/pit_ext_sync.sv
  - hdl/pit_channel.sv
  - hdl/pit_regfile.sv
  - hdl/pit_top.sv
  - target: test
    files:
      - dv/pit_checker.sv
      - dv/pit_tb.sv
